//--- Bender.yml
package:
  name: discrete_audio_chain

sources:
  - files:
      - verilog/discrete_pkg.sv
      - verilog/rc_low_pass_stage.sv
      - verilog/rc_high_pass_stage.sv
      - verilog/gain_saturate_stage.sv
      - verilog/discrete_audio_chain.sv
  - target: simulation
    files:
      - sim/discrete_audio_chain_asserts.sv
      - sim/discrete_audio_chain_tb.sv

//--- sim/discrete_audio_chain_asserts.sv
// --------------------
// Handshake assertions for the chain output.
// Bound into discrete_audio_chain from the bottom of this file.
// --------------------
module discrete_audio_chain_asserts (
    input logic                  clk,
    input logic                  arst_n,
    input discrete_pkg::sample_t out_sample,
    input logic                  out_valid,
    input logic                  out_ready
);

    // Payload is frozen while a stalled output waits
    stable_while_stalled: assert property (
        @(posedge clk) disable iff (!arst_n)
        (out_valid && !out_ready) |=> $stable(out_sample)
    ) else $error("out_sample changed while stalled");

    // No output during reset
    idle_in_reset: assert property (
        @(posedge clk) !arst_n |-> !out_valid
    ) else $error("out_valid high during reset");

    // Valid is only withdrawn after acceptance
    valid_until_accepted: assert property (
        @(posedge clk) disable iff (!arst_n)
        (out_valid && !out_ready) |=> out_valid
    ) else $error("out_valid dropped before acceptance");

endmodule

bind discrete_audio_chain discrete_audio_chain_asserts i_discrete_audio_chain_asserts (
    .clk        (clk),
    .arst_n     (arst_n),
    .out_sample (out_sample),
    .out_valid  (out_valid),
    .out_ready  (out_ready)
);

//--- sim/discrete_audio_chain_tb.sv
// --------------------
// Testbench for the discrete audio chain.
// Test data sections plus a generated saturation section, the DUT
// reset at each new section and every output handshake checked in
// order. One section runs with random stalls and gaps.
// --------------------
module discrete_audio_chain_tb;
    import discrete_pkg::*;

    localparam string DATA_FILE  = "sim/discrete_audio_chain_testdata.txt";
    localparam int    BP_SECTION = 7;
    localparam int    RESET_CYCLES = 16;
    localparam int    SAT_SECTION  = 8;
    localparam int    SAT_UP_LEN   = 40;
    localparam int    SAT_DOWN_LEN = 72;

    logic    clk = 1'b0;
    logic    arst_n;
    gain_t   gain;
    sample_t in_sample;
    logic    in_valid;
    logic    in_ready;
    sample_t out_sample;
    logic    out_valid;
    logic    out_ready;

    // Test data, one entry per data line
    int      line_sec[$];
    gain_t   line_gain[$];
    sample_t line_in[$];
    sample_t line_exp[$];

    // Expected outputs in flight, popped on each output handshake
    sample_t exp_q[$];
    int      exp_sec_q[$];

    int      checked     = 0;
    int      cycles      = 0;
    int      cycle_limit = 200;
    logic    bp_mode;

    discrete_audio_chain i_discrete_audio_chain (
        .clk        (clk),
        .arst_n     (arst_n),
        .gain       (gain),
        .in_sample  (in_sample),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .out_sample (out_sample),
        .out_valid  (out_valid),
        .out_ready  (out_ready)
    );

    always #4 clk = ~clk;

    task automatic check_sample(input sample_t actual, input sample_t expected,
                                input int section);
        if (actual !== expected) begin
            $display("Mismatch at time %0t: section %0d out_sample %0d, expected %0d",
                     $time, section, actual, expected);
            $display("Test failures found");
            $fatal(1, "output sample check failed");
        end
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            $display("Mismatch at time %0t: %s is %b, expected %b",
                     $time, what, actual, expected);
            $display("Test failures found");
            $fatal(1, "handshake flag check failed");
        end
    endtask

    task automatic load_testdata();
        int    fd;
        int    n;
        int    sec;
        int    g;
        int    x;
        int    y;
        string line;
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the test data file %s", DATA_FILE);
            $display("Test failures found");
            $fatal(1, "missing test data");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                // Skip blank and comment lines
                if (line.len() > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%d %d %d %d", sec, g, x, y);
                    if (n == 4) begin
                        line_sec.push_back(sec);
                        line_gain.push_back(gain_t'(g));
                        line_in.push_back(sample_t'(x));
                        line_exp.push_back(sample_t'(y));
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // One sample through low-pass, high-pass and gain by the stage formulas
    function automatic sample_t chain_model(input sample_t x, input gain_t g,
                                            inout longint lp_y, inout longint hp_x,
                                            inout longint hp_y);
        longint scaled;
        lp_y   = lp_y + ((ALPHA_LP * (x - lp_y)) >>> COEF_FRAC_BITS);
        hp_y   = longint'(sample_t'((ALPHA_HP * (hp_y + lp_y - hp_x)) >>> COEF_FRAC_BITS));
        hp_x   = lp_y;
        scaled = (hp_y * longint'(g)) >>> GAIN_FRAC_BITS;
        if (scaled > 32767) begin
            scaled = 32767;
        end else if (scaled < -32768) begin
            scaled = -32768;
        end
        return sample_t'(scaled);
    endfunction

    // Full-scale steps up then down at the largest gain push the output
    // into both clamps
    task automatic add_saturation_section();
        sample_t x;
        longint  lp_y;
        longint  hp_x;
        longint  hp_y;
        lp_y = 0;
        hp_x = 0;
        hp_y = 0;
        for (int i = 0; i < SAT_UP_LEN + SAT_DOWN_LEN; i++) begin
            x = (i < SAT_UP_LEN) ? SAMPLE_MAX : SAMPLE_MIN;
            line_sec.push_back(SAT_SECTION);
            line_gain.push_back(gain_t'(255));
            line_in.push_back(x);
            line_exp.push_back(chain_model(x, gain_t'(255), lp_y, hp_x, hp_y));
        end
    endtask

    // Wait until every driven sample has come out
    task automatic drain_pipeline();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
    endtask

    // Reset the DUT, set the section gain and confirm the idle state
    task automatic start_section(input int sec, input gain_t g);
        bp_mode <= 1'b0;
        arst_n  <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
        gain   <= g;
        @(posedge clk);
        check_flag(out_valid, 1'b0, "out_valid after reset");
        check_flag(in_ready, 1'b1, "in_ready after reset");
        bp_mode <= (sec == BP_SECTION);
    endtask

    // Sink side, random stalls only in the back-pressure section
    always @(posedge clk) begin
        if (bp_mode) begin
            out_ready <= ($urandom % 2) == 0;
        end else begin
            out_ready <= 1'b1;
        end
    end

    always @(posedge clk) begin : monitor
        sample_t expected;
        int      section;
        if (arst_n && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                $display("An output arrived at time %0t with no sample pending", $time);
                $display("Test failures found");
                $fatal(1, "unexpected output");
            end else begin
                expected = exp_q.pop_front();
                section  = exp_sec_q.pop_front();
                check_sample(out_sample, expected, section);
                checked = checked + 1;
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles before all test data was checked", cycles);
            $display("Test failures found");
            $fatal(1, "timeout");
        end
    end

    initial begin
        int cur_sec;
        int gap;
        void'($urandom(44));
        arst_n    = 1'b0;
        gain      = gain_t'(64);
        in_sample = '0;
        in_valid  = 1'b0;
        out_ready = 1'b1;
        bp_mode   = 1'b0;
        load_testdata();
        add_saturation_section();
        cycle_limit = 4 * line_in.size() + 200;
        cur_sec = -1;
        for (int i = 0; i < line_in.size(); i++) begin
            if (line_sec[i] != cur_sec) begin
                in_valid <= 1'b0;
                drain_pipeline();
                start_section(line_sec[i], line_gain[i]);
                cur_sec = line_sec[i];
            end
            if (cur_sec == BP_SECTION) begin
                gap = $urandom % 3;
                repeat (gap) begin
                    in_valid <= 1'b0;
                    @(posedge clk);
                end
            end
            in_sample <= line_in[i];
            in_valid  <= 1'b1;
            exp_q.push_back(line_exp[i]);
            exp_sec_q.push_back(line_sec[i]);
            @(posedge clk);
            while (!in_ready) begin
                @(posedge clk);
            end
        end
        in_valid <= 1'b0;
        drain_pipeline();
        @(posedge clk);
        if (checked == line_in.size() && line_in.size() > 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("Only %0d of %0d expected outputs were checked", checked, line_in.size());
            $display("Test failures found");
            $fatal(1, "incomplete run");
        end
    end

endmodule

//--- sim/discrete_audio_chain_testdata.txt
# Columns: section gain input_sample expected_output (signed decimal)
# The DUT is reset at the start of every section; section 7 runs with stalls
# 1: impulse at unity gain
1 64 10000 92
1 64 0 90
1 64 0 88
# 2: low-pass step at unity gain
2 64 20000 185
2 64 20000 369
2 64 20000 550
2 64 20000 729
2 64 20000 905
# 3: constant low-pass level, high-pass output decays
3 64 32767 304
3 64 305 303
3 64 305 302
3 64 305 301
3 64 305 300
3 64 305 299
# 4: impulse at half gain
4 32 10000 46
4 32 0 45
4 32 0 44
# 5: impulse at the largest gain
5 255 10000 366
5 255 0 358
5 255 0 350
# 6: negative impulse at half gain, arithmetic shift
6 32 -10000 -47
6 32 0 -47
# 7: step of section 2 under random back-pressure and input gaps
7 64 20000 185
7 64 20000 369
7 64 20000 550
7 64 20000 729
7 64 20000 905

//--- src.f
verilog/discrete_pkg.sv
verilog/rc_low_pass_stage.sv
verilog/rc_high_pass_stage.sv
verilog/gain_saturate_stage.sv
verilog/discrete_audio_chain.sv
sim/discrete_audio_chain_asserts.sv
sim/discrete_audio_chain_tb.sv

//--- verilog/discrete_audio_chain.sv
// --------------------
// Discrete audio chain top level.
// Low-pass, high-pass and gain stages in a valid/ready pipeline,
// three cycles of latency and one sample per cycle throughput.
// --------------------
module discrete_audio_chain (
    input  logic                 clk,
    input  logic                 arst_n,
    input  discrete_pkg::gain_t   gain,
    input  discrete_pkg::sample_t in_sample,
    input  logic                 in_valid,
    output logic                 in_ready,
    output discrete_pkg::sample_t out_sample,
    output logic                 out_valid,
    input  logic                 out_ready
);
    import discrete_pkg::*;

    // Low-pass to high-pass link
    sample_t lp_sample;
    logic    lp_valid;
    logic    lp_ready;

    // High-pass to gain link
    sample_t hp_sample;
    logic    hp_valid;
    logic    hp_ready;

    rc_low_pass_stage i_rc_low_pass_stage (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_sample  (in_sample),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .out_sample (lp_sample),
        .out_valid  (lp_valid),
        .out_ready  (lp_ready)
    );

    rc_high_pass_stage i_rc_high_pass_stage (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_sample  (lp_sample),
        .in_valid   (lp_valid),
        .in_ready   (lp_ready),
        .out_sample (hp_sample),
        .out_valid  (hp_valid),
        .out_ready  (hp_ready)
    );

    // Last stage, back-pressure from out_ready ripples upstream from here
    gain_saturate_stage i_gain_saturate_stage (
        .clk        (clk),
        .arst_n     (arst_n),
        .gain       (gain),
        .in_sample  (hp_sample),
        .in_valid   (hp_valid),
        .in_ready   (hp_ready),
        .out_sample (out_sample),
        .out_valid  (out_valid),
        .out_ready  (out_ready)
    );

endmodule

//--- verilog/discrete_pkg.sv
// --------------------
// Shared sample and gain types for the discrete audio path.
// Filter coefficients come from the component values below at
// elaboration time; modules import this package in their body.
// --------------------
package discrete_pkg;

    // Audio sample format
    localparam int SAMPLE_W = 16;

    typedef logic signed [SAMPLE_W-1:0] sample_t;

    localparam sample_t SAMPLE_MAX = {1'b0, {(SAMPLE_W-1){1'b1}}};
    localparam sample_t SAMPLE_MIN = {1'b1, {(SAMPLE_W-1){1'b0}}};

    // Gain is unsigned fixed point, 64 is unity
    localparam int GAIN_W         = 8;
    localparam int GAIN_FRAC_BITS = 6;

    typedef logic [GAIN_W-1:0] gain_t;

    localparam longint SAMPLE_RATE = 48000;

    // Low-pass components, capacitor held as farads <<< 35
    localparam longint LP_R            = 47000;
    localparam longint LP_C_35_SHIFTED = 1615;

    // High-pass components, 8.2k and 1 uF put the corner near 19.4 Hz
    localparam longint HP_R            = 8200;
    localparam longint HP_C_35_SHIFTED = 34360;

    // Coefficients carry 16 fraction bits plus headroom for the sign
    localparam int COEF_FRAC_BITS = 16;
    localparam int COEF_W         = COEF_FRAC_BITS + 2;

    // Sample period and RC products, all in seconds <<< 32
    localparam longint DT_32_SHIFTED    = (longint'(1) <<< 32) / SAMPLE_RATE;
    localparam longint LP_RC_32_SHIFTED = (LP_R * LP_C_35_SHIFTED) >>> 3;
    localparam longint HP_RC_32_SHIFTED = (HP_R * HP_C_35_SHIFTED) >>> 3;

    // Smoothing factor dt / (RC + dt)
    localparam logic signed [COEF_W-1:0] ALPHA_LP = COEF_W'(
        (DT_32_SHIFTED <<< COEF_FRAC_BITS) / (LP_RC_32_SHIFTED + DT_32_SHIFTED)
    );

    // Decay factor RC / (RC + dt)
    localparam logic signed [COEF_W-1:0] ALPHA_HP = COEF_W'(
        (HP_RC_32_SHIFTED <<< COEF_FRAC_BITS) / (HP_RC_32_SHIFTED + DT_32_SHIFTED)
    );

endpackage

//--- verilog/gain_saturate_stage.sv
// --------------------
// Gain stage with saturation.
// Gain is sampled together with the accepted sample; the scaled
// value is clamped to the signed 16-bit range and registered.
// --------------------
module gain_saturate_stage (
    input  logic                 clk,
    input  logic                 arst_n,
    input  discrete_pkg::gain_t   gain,
    input  discrete_pkg::sample_t in_sample,
    input  logic                 in_valid,
    output logic                 in_ready,
    output discrete_pkg::sample_t out_sample,
    output logic                 out_valid,
    input  logic                 out_ready
);
    import discrete_pkg::*;

    logic                             accept;

    // Signed sample times zero-extended gain
    logic signed [SAMPLE_W+GAIN_W:0]  prod;
    logic signed [SAMPLE_W+GAIN_W:0]  scaled;
    sample_t                          clamped;
    sample_t                          out_q;

    assign in_ready = !out_valid || out_ready;
    assign accept   = in_valid && in_ready;

    assign prod   = in_sample * $signed({1'b0, gain});
    assign scaled = prod >>> GAIN_FRAC_BITS;

    always_comb begin
        if (scaled > SAMPLE_MAX) begin
            clamped = SAMPLE_MAX;
        end else if (scaled < SAMPLE_MIN) begin
            clamped = SAMPLE_MIN;
        end else begin
            clamped = sample_t'(scaled);
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_q <= clamped;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (accept) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    assign out_sample = out_q;

endmodule

//--- verilog/rc_high_pass_stage.sv
// --------------------
// First-order RC high-pass stage that strips DC offset.
// Tracks the previous input and output; a constant input decays
// toward zero. Same handshake and latency as the low-pass stage.
// --------------------
module rc_high_pass_stage (
    input  logic                 clk,
    input  logic                 arst_n,
    input  discrete_pkg::sample_t in_sample,
    input  logic                 in_valid,
    output logic                 in_ready,
    output discrete_pkg::sample_t out_sample,
    output logic                 out_valid,
    input  logic                 out_ready
);
    import discrete_pkg::*;

    sample_t                           x_prev_q;
    sample_t                           y_prev_q;
    logic                              accept;

    // y + x - x_prev spans two extra bits
    logic signed [SAMPLE_W+1:0]        sum;
    logic signed [COEF_W+SAMPLE_W+1:0] prod;
    sample_t                           y_next;

    assign in_ready = !out_valid || out_ready;
    assign accept   = in_valid && in_ready;

    // y = alpha * (y_prev + x - x_prev)
    assign sum  = y_prev_q + in_sample - x_prev_q;
    assign prod = ALPHA_HP * sum;

    // Result truncated to the sample width
    assign y_next = sample_t'(prod >>> COEF_FRAC_BITS);

    // History only moves on accepted samples so stalls are invisible
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            x_prev_q <= '0;
            y_prev_q <= '0;
        end else if (accept) begin
            x_prev_q <= in_sample;
            y_prev_q <= y_next;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (accept) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    assign out_sample = y_prev_q;

endmodule

//--- verilog/rc_low_pass_stage.sv
// --------------------
// First-order RC low-pass stage.
// One update per accepted sample, result held in a registered
// valid/ready output slot with one cycle of latency.
// --------------------
module rc_low_pass_stage (
    input  logic                 clk,
    input  logic                 arst_n,
    input  discrete_pkg::sample_t in_sample,
    input  logic                 in_valid,
    output logic                 in_ready,
    output discrete_pkg::sample_t out_sample,
    output logic                 out_valid,
    input  logic                 out_ready
);
    import discrete_pkg::*;

    // Previous output, which is also the filter state
    sample_t                           y_q;
    logic                              accept;

    // Difference needs one extra bit to avoid wrap
    logic signed [SAMPLE_W:0]          diff;
    logic signed [COEF_W+SAMPLE_W-1:0] prod;
    sample_t                           y_next;

    // Slot is free when empty or being drained this cycle
    assign in_ready = !out_valid || out_ready;
    assign accept   = in_valid && in_ready;

    // y += alpha * (x - y), product scaled back by the fraction bits
    assign diff   = in_sample - y_q;
    assign prod   = ALPHA_LP * diff;
    assign y_next = y_q + sample_t'(prod >>> COEF_FRAC_BITS);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            y_q <= '0;
        end else if (accept) begin
            y_q <= y_next;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (accept) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // The state register doubles as the output payload
    assign out_sample = y_q;

endmodule
